//--- all.f
rtl/vec_pkg.sv
rtl/vec_regfile.sv
rtl/vec_lane_alu.sv
rtl/vec_issue.sv
rtl/vec_unit_top.sv
sim/vec_unit_tb.sv

//--- Makefile
# Verilator flow for the vector execution slice

VERILATOR ?= verilator
TOP       ?= vec_unit_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/vec_unit_tb.sv
/*
 * Testbench for the vector execution slice
 * Table of commands, shadow register file and random result back-pressure
 */
`timescale 1ns/10ps

module vec_unit_tb;

    import vec_pkg::*;

    localparam int nb             = VEC_BYTES;
    localparam int data_w         = BYTE_W * nb;
    localparam int timeout_cycles = 200;
    localparam logic [nb-1:0] full = '1;

    typedef enum int {ROW_LOAD, ROW_CMD, ROW_SWEEP} row_kind_e;

    typedef struct {
        row_kind_e     kind;
        vec_op_e       op;
        vec_addr_t     rs_a;
        vec_addr_t     rs_b;
        vec_addr_t     rd;
        logic [nb-1:0] mask;
        logic [7:0]    pat;
        logic [7:0]    step;
        bit            chk;
        logic [7:0]    exp;
    } row_t;

    typedef struct {
        int                row;
        vec_addr_t         rd;
        logic [data_w-1:0] data;
        logic [nb-1:0]     mask;
    } pend_t;

    logic              clk;
    logic              arst_n;
    logic              cmd_valid;
    logic              cmd_ready;
    vec_op_e           cmd_op;
    vec_addr_t         cmd_rs_a;
    vec_addr_t         cmd_rs_b;
    vec_addr_t         cmd_rd;
    logic [nb-1:0]     cmd_mask;
    logic              res_valid;
    logic              res_ready;
    vec_addr_t         res_rd;
    logic [data_w-1:0] res_data;
    logic [nb-1:0]     res_mask;
    vec_addr_t         dbg_addr;
    logic [data_w-1:0] dbg_data;

    row_t              rows [$];
    pend_t             pend_q [$];
    logic [data_w-1:0] shadow [VEC_REGS];
    bit                written [VEC_REGS];
    logic [data_w-1:0] inject;
    int                cmd_row;
    int                errors;
    int                n_checks;
    int                n_accepted;
    int                n_retired;
    bit                aborted;
    bit                hold_prev;
    vec_addr_t         prev_rd;
    logic [data_w-1:0] prev_data;
    logic [nb-1:0]     prev_mask;
    integer            seed = 4;

    vec_unit_top #(
        .num_bytes (nb)
    ) vec_unit_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_op    (cmd_op),
        .cmd_rs_a  (cmd_rs_a),
        .cmd_rs_b  (cmd_rs_b),
        .cmd_rd    (cmd_rd),
        .cmd_mask  (cmd_mask),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .res_mask  (res_mask),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Random result back-pressure with ready about three cycles in four
    initial begin : ready_gen
        res_ready = 1'b0;
        forever begin
            @(posedge clk);
            res_ready <= ($random(seed) % 4) != 0;
        end
    end

    task automatic check(input string name, input logic [data_w-1:0] got,
                         input logic [data_w-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [data_w-1:0] alu_model(vec_op_e op, logic [data_w-1:0] a,
                                                    logic [data_w-1:0] b);
        logic [data_w-1:0] r;
        logic [7:0]        x;
        logic [7:0]        y;
        for (int i = 0; i < nb; i++) begin
            x = a[i*8 +: 8];
            y = b[i*8 +: 8];
            case (op)
                OP_ADD:  r[i*8 +: 8] = x + y;
                OP_SUB:  r[i*8 +: 8] = x - y;
                OP_AND:  r[i*8 +: 8] = x & y;
                OP_OR:   r[i*8 +: 8] = x | y;
                OP_XOR:  r[i*8 +: 8] = x ^ y;
                OP_MINU: r[i*8 +: 8] = (x < y) ? x : y;
                OP_MOVA: r[i*8 +: 8] = x;
                default: r[i*8 +: 8] = 8'h00;
            endcase
        end
        return r;
    endfunction

    // Byte i holds pat + i * step
    function automatic logic [data_w-1:0] fill_vec(logic [7:0] pat, logic [7:0] step);
        logic [data_w-1:0] v;
        for (int i = 0; i < nb; i++) begin
            v[i*8 +: 8] = pat + 8'(i) * step;
        end
        return v;
    endfunction

    task automatic add_row(row_kind_e kind, vec_op_e op, int rs_a, int rs_b, int rd,
                           logic [nb-1:0] mask, int pat, int step, bit chk, int exp);
        row_t r;
        r.kind = kind;
        r.op   = op;
        r.rs_a = vec_addr_t'(rs_a);
        r.rs_b = vec_addr_t'(rs_b);
        r.rd   = vec_addr_t'(rd);
        r.mask = mask;
        r.pat  = 8'(pat);
        r.step = 8'(step);
        r.chk  = chk;
        r.exp  = 8'(exp);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Seed loads with two flat and two varying vectors
        add_row(ROW_LOAD,  OP_MOVA, 1, 0, 1, full, 'h5A, 0, 0, 0);
        add_row(ROW_LOAD,  OP_MOVA, 2, 0, 2, full, 'hC3, 0, 0, 0);
        add_row(ROW_LOAD,  OP_MOVA, 3, 0, 3, full, 'hF0, 'h1B, 0, 0);
        add_row(ROW_LOAD,  OP_MOVA, 4, 0, 4, full, 'h37, 'h29, 0, 0);
        // Every operation with hand-worked results
        add_row(ROW_CMD,   OP_ADD,  1, 2, 8,  full, 0, 0, 1, 'h1D);
        add_row(ROW_CMD,   OP_SUB,  1, 2, 9,  full, 0, 0, 1, 'h97);
        add_row(ROW_CMD,   OP_AND,  1, 2, 10, full, 0, 0, 1, 'h42);
        add_row(ROW_CMD,   OP_OR,   1, 2, 11, full, 0, 0, 1, 'hDB);
        add_row(ROW_CMD,   OP_XOR,  1, 2, 12, full, 0, 0, 1, 'h99);
        add_row(ROW_CMD,   OP_MINU, 1, 2, 13, full, 0, 0, 1, 'h5A);
        add_row(ROW_CMD,   OP_MOVA, 2, 1, 14, full, 0, 0, 1, 'hC3);
        add_row(ROW_CMD,   OP_SUB,  2, 1, 15, full, 0, 0, 1, 'h69);
        add_row(ROW_SWEEP, OP_MOVA, 0, 0, 0, '0, 0, 0, 0, 0);
        // Partial masks
        add_row(ROW_CMD,   OP_XOR,  3, 4, 8,  16'hF0F0, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_MOVA, 2, 2, 1,  16'h0001, 0, 0, 1, 'hC3);
        add_row(ROW_CMD,   OP_OR,   1, 1, 9,  16'h8001, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_AND,  3, 4, 10, 16'h0000, 0, 0, 0, 0);
        add_row(ROW_SWEEP, OP_MOVA, 0, 0, 0, '0, 0, 0, 0, 0);
        // Dependent chain through the write bypass
        add_row(ROW_CMD,   OP_ADD,  3,  4,  20, full, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_ADD,  20, 4,  20, full, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_SUB,  20, 3,  21, full, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_XOR,  21, 20, 20, full, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_MINU, 20, 21, 21, 16'h5555, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_ADD,  21, 21, 22, full, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_MOVA, 22, 0,  3,  16'hFF00, 0, 0, 0, 0);
        add_row(ROW_CMD,   OP_ADD,  3,  20, 23, full, 0, 0, 0, 0);
        // Each row reads the destination of the row before
        for (int i = 0; i < 12; i++) begin
            add_row(ROW_CMD, vec_op_e'(i % 7), 20 + i % 4, 20 + (i + 3) % 4,
                    20 + (i + 1) % 4,
                    (i % 3 == 0) ? full : ((i % 3 == 1) ? 16'h0FF0 : 16'hA5C3),
                    0, 0, 0, 0);
        end
        add_row(ROW_SWEEP, OP_MOVA, 0, 0, 0, '0, 0, 0, 0, 0);
    endtask

    task automatic wait_accept(input int idx);
        bit done;
        done = 1'b0;
        for (int n = 0; n < timeout_cycles && !done; n++) begin
            @(posedge clk);
            done = cmd_valid && cmd_ready;
        end
        if (!done) begin
            $display("Timeout: the command of row %0d was never accepted", idx);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_drain(input int idx);
        bit done;
        done = 1'b0;
        for (int n = 0; n < timeout_cycles && !done; n++) begin
            @(posedge clk);
            done = (n_accepted == n_retired) && !res_valid;
        end
        if (!done) begin
            $display("Timeout: results still outstanding before row %0d", idx);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic issue_row(input int idx);
        row_t r;
        r = rows[idx];
        cmd_valid <= 1'b1;
        cmd_op    <= r.op;
        cmd_rs_a  <= r.rs_a;
        cmd_rs_b  <= r.rs_b;
        cmd_rd    <= r.rd;
        cmd_mask  <= r.mask;
        cmd_row   <= idx;
        if (r.kind == ROW_LOAD) begin
            // Seed data enters on the A operand path and MOVA copies it
            @(negedge clk);
            inject = fill_vec(r.pat, r.step);
            force vec_unit_top_i.opnd_a = inject;
        end
        wait_accept(idx);
        if (r.kind == ROW_LOAD) begin
            cmd_valid <= 1'b0;
            @(negedge clk);
            release vec_unit_top_i.opnd_a;
            @(posedge clk);
        end
    endtask

    task automatic sweep_regs(input int idx);
        int err_before;
        int cnt;
        cmd_valid <= 1'b0;
        wait_drain(idx);
        if (!aborted) begin
            err_before = errors;
            cnt = 0;
            for (int r = 0; r < VEC_REGS; r++) begin
                if (written[r]) begin
                    dbg_addr <= vec_addr_t'(r);
                    @(posedge clk);
                    check($sformatf("dbg_data r%0d", r), dbg_data, shadow[r]);
                    cnt++;
                end
            end
            $display("row %0d sweep of %0d registers %s", idx, cnt,
                     (errors == err_before) ? "ok" : "FAILED");
        end
    endtask

    // Retire before accept so a same-edge write reaches the new operands
    always @(posedge clk) begin : monitor
        pend_t p;
        row_t  r;
        int    err_before;
        string what;
        if (arst_n) begin
            if (hold_prev) begin
                check("res_valid held", data_w'(res_valid), data_w'(1'b1));
                check("res_rd held", data_w'(res_rd), data_w'(prev_rd));
                check("res_data held", res_data, prev_data);
                check("res_mask held", data_w'(res_mask), data_w'(prev_mask));
            end
            if (res_valid && res_ready) begin
                if (pend_q.size() == 0) begin
                    $display("Result for r%0d appeared with no command outstanding", res_rd);
                    errors++;
                end else begin
                    p = pend_q.pop_front();
                    r = rows[p.row];
                    err_before = errors;
                    check("res_rd", data_w'(res_rd), data_w'(p.rd));
                    check("res_data", res_data, p.data);
                    check("res_mask", data_w'(res_mask), data_w'(p.mask));
                    if (r.chk) begin
                        check("res_data directed", res_data, {nb{r.exp}});
                    end
                    for (int b = 0; b < nb; b++) begin
                        if (p.mask[b]) begin
                            shadow[p.rd][b*8 +: 8] = p.data[b*8 +: 8];
                        end
                    end
                    written[p.rd] = 1'b1;
                    n_retired++;
                    what = r.op.name();
                    if (r.kind == ROW_LOAD) begin
                        what = "load";
                    end
                    $display("row %0d %s r%0d mask %h %s", p.row, what, p.rd, p.mask,
                             (errors == err_before) ? "ok" : "FAILED");
                end
            end
            if (cmd_valid && cmd_ready) begin
                r = rows[cmd_row];
                if (r.kind == ROW_LOAD) begin
                    p.data = fill_vec(r.pat, r.step);
                end else begin
                    p.data = alu_model(r.op, shadow[r.rs_a], shadow[r.rs_b]);
                end
                p.row  = cmd_row;
                p.rd   = r.rd;
                p.mask = r.mask;
                pend_q.push_back(p);
                n_accepted++;
            end
            hold_prev = res_valid && !res_ready;
            prev_rd   = res_rd;
            prev_data = res_data;
            prev_mask = res_mask;
        end
    end

    initial begin : main
        int err_before;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_ADD;
        cmd_rs_a  = '0;
        cmd_rs_b  = '0;
        cmd_rd    = '0;
        cmd_mask  = '0;
        dbg_addr  = '0;
        cmd_row   = 0;
        build_table();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        err_before = errors;
        check("res_valid", data_w'(res_valid), '0);
        check("cmd_ready", data_w'(cmd_ready), data_w'(1'b1));
        $display("reset state %s", (errors == err_before) ? "ok" : "FAILED");
        for (int i = 0; i < rows.size() && !aborted; i++) begin
            if (rows[i].kind == ROW_SWEEP) begin
                sweep_regs(i);
            end else begin
                issue_row(i);
            end
        end
        $display("%0d rows, %0d commands, %0d results, %0d checks, %0d errors",
                 rows.size(), n_accepted, n_retired, n_checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rtl/vec_unit_top.sv
/*
 * Vector execution slice
 * Issue stage, byte-lane ALU and bypassed register file
 */
`timescale 1ns/10ps

module vec_unit_top #(
    parameter int num_bytes = vec_pkg::VEC_BYTES
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  vec_pkg::vec_op_e                    cmd_op,
    input  vec_pkg::vec_addr_t                  cmd_rs_a,
    input  vec_pkg::vec_addr_t                  cmd_rs_b,
    input  vec_pkg::vec_addr_t                  cmd_rd,
    input  logic [num_bytes-1:0]                cmd_mask,

    output logic                                res_valid,
    input  logic                                res_ready,
    output vec_pkg::vec_addr_t                  res_rd,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] res_data,
    output logic [num_bytes-1:0]                res_mask,

    input  vec_pkg::vec_addr_t                  dbg_addr,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] dbg_data
);

    import vec_pkg::*;

    localparam int data_w = BYTE_W * num_bytes;

    vec_addr_t             rd_addr_a;
    vec_addr_t             rd_addr_b;
    logic [data_w-1:0]     opnd_a;
    logic [data_w-1:0]     opnd_b;
    vec_op_e               alu_op;
    logic [data_w-1:0]     alu_result;
    vec_addr_t             wr_addr;
    logic [data_w-1:0]     wr_data;
    logic [num_bytes-1:0]  wr_en;

    vec_issue #(
        .num_bytes (num_bytes)
    ) vec_issue_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_rs_a   (cmd_rs_a),
        .cmd_rs_b   (cmd_rs_b),
        .cmd_rd     (cmd_rd),
        .cmd_mask   (cmd_mask),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_rd     (res_rd),
        .res_data   (res_data),
        .res_mask   (res_mask),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_en      (wr_en)
    );

    vec_lane_alu #(
        .num_bytes (num_bytes)
    ) vec_lane_alu_i (
        .op     (alu_op),
        .opnd_a (opnd_a),
        .opnd_b (opnd_b),
        .result (alu_result)
    );

    vec_regfile #(
        .num_bytes (num_bytes)
    ) vec_regfile_i (
        .clk       (clk),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (opnd_a),
        .rd_data_b (opnd_b),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

endmodule

//--- rtl/vec_issue.sv
/*
 * Issue and execute stage
 * Accepts commands, holds one result in a register stage and
 * writes it back under its byte mask when the result is taken
 */
`timescale 1ns/10ps

module vec_issue #(
    parameter int num_bytes = vec_pkg::VEC_BYTES
) (
    input  logic                                clk,
    input  logic                                arst_n,

    // Command side
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  vec_pkg::vec_op_e                    cmd_op,
    input  vec_pkg::vec_addr_t                  cmd_rs_a,
    input  vec_pkg::vec_addr_t                  cmd_rs_b,
    input  vec_pkg::vec_addr_t                  cmd_rd,
    input  logic [num_bytes-1:0]                cmd_mask,

    // Operand fetch and ALU
    output vec_pkg::vec_addr_t                  rd_addr_a,
    output vec_pkg::vec_addr_t                  rd_addr_b,
    output vec_pkg::vec_op_e                    alu_op,
    input  logic [vec_pkg::BYTE_W*num_bytes-1:0] alu_result,

    // Result side
    output logic                                res_valid,
    input  logic                                res_ready,
    output vec_pkg::vec_addr_t                  res_rd,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] res_data,
    output logic [num_bytes-1:0]                res_mask,

    // Write-back
    output vec_pkg::vec_addr_t                  wr_addr,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] wr_data,
    output logic [num_bytes-1:0]                wr_en
);

    logic stage_valid;
    logic retire;
    logic accept;

    // Operands are fetched straight from the offered command
    assign rd_addr_a = cmd_rs_a;
    assign rd_addr_b = cmd_rs_b;
    assign alu_op    = cmd_op;

    assign retire    = stage_valid && res_ready;
    // Free stage, or one that empties on this edge
    assign cmd_ready = !stage_valid || retire;
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else if (accept) begin
            stage_valid <= 1'b1;
        end else if (retire) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_data <= alu_result;
            res_rd   <= cmd_rd;
            res_mask <= cmd_mask;
        end
    end

    assign res_valid = stage_valid;

    // Write lands on the same edge the result is taken
    assign wr_addr = res_rd;
    assign wr_data = res_data;
    assign wr_en   = retire ? res_mask : '0;

endmodule

//--- rtl/vec_lane_alu.sv
/*
 * Byte-lane ALU
 * Applies one operation to every byte of two vectors, lanes independent
 */
`timescale 1ns/10ps

module vec_lane_alu #(
    parameter int num_bytes = vec_pkg::VEC_BYTES
) (
    input  vec_pkg::vec_op_e                    op,
    input  logic [vec_pkg::BYTE_W*num_bytes-1:0] opnd_a,
    input  logic [vec_pkg::BYTE_W*num_bytes-1:0] opnd_b,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] result
);

    import vec_pkg::*;

    for (genvar i = 0; i < num_bytes; i++) begin : g_lane
        logic [BYTE_W-1:0] lane_a;
        logic [BYTE_W-1:0] lane_b;
        logic [BYTE_W-1:0] lane_r;

        assign lane_a = opnd_a[i*BYTE_W +: BYTE_W];
        assign lane_b = opnd_b[i*BYTE_W +: BYTE_W];

        // Add and subtract wrap within the lane
        always_comb begin
            case (op)
                OP_ADD: begin
                    lane_r = lane_a + lane_b;
                end
                OP_SUB: begin
                    lane_r = lane_a - lane_b;
                end
                OP_AND: begin
                    lane_r = lane_a & lane_b;
                end
                OP_OR: begin
                    lane_r = lane_a | lane_b;
                end
                OP_XOR: begin
                    lane_r = lane_a ^ lane_b;
                end
                OP_MINU: begin
                    lane_r = (lane_a < lane_b) ? lane_a : lane_b;
                end
                OP_MOVA: begin
                    lane_r = lane_a;
                end
                // Unused code gives zero
                default: begin
                    lane_r = '0;
                end
            endcase
        end

        assign result[i*BYTE_W +: BYTE_W] = lane_r;
    end

endmodule

//--- rtl/vec_regfile.sv
/*
 * Vector register file
 * Two asynchronous read ports with write bypass, one byte-enabled
 * write port and a plain inspection read port
 */
`timescale 1ns/10ps

module vec_regfile #(
    parameter int num_bytes = vec_pkg::VEC_BYTES
) (
    input  logic                                clk,
    input  vec_pkg::vec_addr_t                  wr_addr,
    input  logic [vec_pkg::BYTE_W*num_bytes-1:0] wr_data,
    input  logic [num_bytes-1:0]                wr_en,
    input  vec_pkg::vec_addr_t                  rd_addr_a,
    input  vec_pkg::vec_addr_t                  rd_addr_b,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] rd_data_a,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] rd_data_b,
    input  vec_pkg::vec_addr_t                  dbg_addr,
    output logic [vec_pkg::BYTE_W*num_bytes-1:0] dbg_data
);

    import vec_pkg::*;

    localparam int data_w = BYTE_W * num_bytes;

    logic [data_w-1:0] regs [VEC_REGS];

    // Read ports gathered so both share one bypass structure
    vec_addr_t         rd_addr [2];
    logic [data_w-1:0] rd_data [2];

    assign rd_addr[0] = rd_addr_a;
    assign rd_addr[1] = rd_addr_b;
    assign rd_data_a  = rd_data[0];
    assign rd_data_b  = rd_data[1];

    // Byte-masked write, contents are not reset
    always_ff @(posedge clk) begin
        for (int b = 0; b < num_bytes; b++) begin
            if (wr_en[b]) begin
                regs[wr_addr][b*BYTE_W +: BYTE_W] <= wr_data[b*BYTE_W +: BYTE_W];
            end
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_rd_port
        logic              addr_hit;
        logic [data_w-1:0] data;

        assign addr_hit = (wr_addr == rd_addr[p]);

        // Enabled bytes of a matching write are forwarded
        always_comb begin
            for (int b = 0; b < num_bytes; b++) begin
                if (addr_hit && wr_en[b]) begin
                    data[b*BYTE_W +: BYTE_W] = wr_data[b*BYTE_W +: BYTE_W];
                end else begin
                    data[b*BYTE_W +: BYTE_W] = regs[rd_addr[p]][b*BYTE_W +: BYTE_W];
                end
            end
        end

        assign rd_data[p] = data;
    end

    // Inspection shows stored state only
    assign dbg_data = regs[dbg_addr];

endmodule

//--- rtl/vec_pkg.sv
/*
 * Vector slice definitions
 * Register file geometry, index type and the byte-lane operation codes
 */
package vec_pkg;

    // Default bytes per vector register
    parameter int VEC_BYTES = 16;

    // Width of one lane
    parameter int BYTE_W = 8;

    // Register file depth and index width
    parameter int VEC_REGS   = 32;
    parameter int VEC_ADDR_W = 5;

    typedef logic [VEC_ADDR_W-1:0] vec_addr_t;

    // Byte-lane operations, no carry between lanes
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,  // A minus B
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_MINU = 3'd5,  // unsigned minimum
        OP_MOVA = 3'd6
    } vec_op_e;

endpackage
